// ==== design/smc_pkg.sv ====
// SMC strobe package holding the controller state encoding and default bus widths
package smc_pkg;

   // --------------------------------------------------
   // Default widths
   // --------------------------------------------------
   localparam int SMC_WS_WIDTH   = 8;  // Wait-state count and store
   localparam int SMC_NUM_BYTES  = 4;  // Byte lanes on the external bus
   localparam int SMC_EDGE_WIDTH = 2;  // Edge-timing counters, also low field of wait values

   // --------------------------------------------------
   // Controller state, one-hot
   // --------------------------------------------------
   typedef enum logic [4:0]
   {
      SMC_IDLE  = 5'b00001,  // No access in progress
      SMC_LE    = 5'b00010,  // Leading edge of strobe
      SMC_RW    = 5'b00100,  // Read/write, strobes active
      SMC_STORE = 5'b01000,  // Store read data
      SMC_FLOAT = 5'b10000   // Bus turnaround
   } smc_state_e;

endpackage

// ==== design/smc_timing_if.sv ====
// SMC timing bundle carrying the wait-state and strobe-edge counters to the strobe paths
interface smc_timing_if
   import smc_pkg::*;
#(
   parameter int ws_width = SMC_WS_WIDTH
)
();

   logic [ws_width-1:0]       ws_count;    // Live wait-state count
   logic [ws_width-1:0]       ws_store;    // Programmed wait states
   logic [SMC_EDGE_WIDTH-1:0] wele_count;  // Write leading edge count
   logic [SMC_EDGE_WIDTH-1:0] wele_store;  // Write leading edge store
   logic [SMC_EDGE_WIDTH-1:0] wete_store;  // Write trailing edge store
   logic [SMC_EDGE_WIDTH-1:0] oete_store;  // Read strobe (OE) trailing edge store

   // Read path only needs wait values and the OE edge
   modport rd_mp
   (
      input ws_count,
      input ws_store,
      input oete_store
   );

   // Write path, all write edge values
   modport wr_mp
   (
      input ws_count,
      input ws_store,
      input wele_count,
      input wele_store,
      input wete_store
   );

endinterface

// ==== design/smc_access_hold.sv ====
// SMC access hold, keeps direction and chip select stable across a multi-cycle access
module smc_access_hold
   import smc_pkg::*;
(
   input  logic sys_clk1,
   input  logic n_sys_reset1,
   input  logic valid_access,  // New access, load values
   input  logic n_read,        // Access direction, low for read
   input  logic cs,            // Chip select of the new access
   input  logic smc_done,      // Current access completed
   input  logic mac_done,      // Last access of a multiple access
   output logic n_r_read,      // Held direction
   output logic r_cs           // Held chip select
);

   logic smc_mac_done;  // Whole transfer finished

   assign smc_mac_done = smc_done & mac_done;

   // --------------------------------------------------
   // Load / clear / hold
   // --------------------------------------------------
   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
      begin
         n_r_read <= 1'b0;
         r_cs     <= 1'b0;
      end
      else if (valid_access)
      begin
         n_r_read <= n_read;  // Load takes priority over done
         r_cs     <= cs;
      end
      else if (smc_mac_done)
      begin
         n_r_read <= 1'b0;
         r_cs     <= 1'b0;
      end
      // Otherwise hold for the rest of the access
   end

   // Chip select only comes up as the result of a load
   a_cs_needs_access: assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1)
      $rose(r_cs) |-> $past(valid_access));

endmodule

// ==== design/smc_rd_strobe.sv ====
// SMC read strobe path, registered active-low read strobe gated by the wait-state timing
module smc_rd_strobe
   import smc_pkg::*;
#(
   parameter int ws_width = SMC_WS_WIDTH
)
(
   input  logic         sys_clk1,
   input  logic         n_sys_reset1,
   input  logic         valid_access,        // New access this cycle
   input  logic         n_read,              // Unregistered direction
   input  logic         n_r_read,            // Held direction
   input  smc_state_e   r_smc_currentstate,
   input  smc_state_e   smc_nextstate,
   smc_timing_if.rd_mp  tim,
   output logic         smc_n_rd             // Read strobe, active low
);

   localparam int HI_WIDTH = ws_width - SMC_EDGE_WIDTH;  // Upper part of a wait value

   logic [HI_WIDTH-1:0]       store_hi;
   logic [SMC_EDGE_WIDTH-1:0] store_lo;
   logic [HI_WIDTH-1:0]       count_hi;
   logic [SMC_EDGE_WIDTH-1:0] count_lo;
   logic                      store_ok;  // Strobe may stay asserted, store based
   logic                      count_ok;  // Same, count based
   logic                      edge_state; // LE or STORE, count not yet loaded

   // --------------------------------------------------
   // Wait value fields
   // --------------------------------------------------
   assign store_hi = tim.ws_store[ws_width-1:SMC_EDGE_WIDTH];
   assign store_lo = tim.ws_store[SMC_EDGE_WIDTH-1:0];
   assign count_hi = tim.ws_count[ws_width-1:SMC_EDGE_WIDTH];
   assign count_lo = tim.ws_count[SMC_EDGE_WIDTH-1:0];

   // Long wait, or OE trailing edge within the wait window
   assign store_ok = (tim.ws_store == '0) | (store_hi != '0) | (tim.oete_store <= store_lo);
   assign count_ok = (tim.ws_count == '0) | (count_hi != '0) | (tim.oete_store < count_lo);

   assign edge_state = (r_smc_currentstate == SMC_LE) | (r_smc_currentstate == SMC_STORE);

   // --------------------------------------------------
   // Strobe register
   // --------------------------------------------------
   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
         smc_n_rd <= 1'b1;
      else if (smc_nextstate != SMC_RW)
         smc_n_rd <= 1'b1;              // Only driven in RW
      else if (valid_access)
         smc_n_rd <= n_read;            // Back-to-back access, fresh direction
      else if (edge_state)
         smc_n_rd <= store_ok ? n_r_read : 1'b1;
      else
         smc_n_rd <= count_ok ? n_r_read : 1'b1;  // Mid access, live count
   end

endmodule

// ==== design/smc_wr_strobe.sv ====
// SMC write strobe path, byte write enables, write strobe, full-cycle flag and drive request
module smc_wr_strobe
   import smc_pkg::*;
#(
   parameter int ws_width  = SMC_WS_WIDTH,
   parameter int num_bytes = SMC_NUM_BYTES
)
(
   input  logic                 sys_clk1,
   input  logic                 n_sys_reset1,
   input  logic                 valid_access,
   input  logic                 n_read,
   input  logic                 n_r_read,
   input  logic                 smc_done,
   input  logic [num_bytes-1:0] n_be,          // Unregistered byte strobes
   input  smc_state_e           r_smc_currentstate,
   input  smc_state_e           smc_nextstate,
   smc_timing_if.wr_mp          tim,
   output logic                 wr_drive,      // Write in progress, to bus control
   output logic [num_bytes-1:0] n_r_we,        // Byte write enables, active low
   output logic                 n_r_wr,        // Write strobe, active low
   output logic                 r_full         // Full-cycle write strobe
);

   localparam int HI_WIDTH = ws_width - SMC_EDGE_WIDTH;

   logic                      wr_cond;
   logic [HI_WIDTH-1:0]       count_hi;
   logic [SMC_EDGE_WIDTH-1:0] count_lo;
   logic [HI_WIDTH-1:0]       store_hi;
   logic [SMC_EDGE_WIDTH-1:0] store_lo;
   logic [SMC_EDGE_WIDTH-1:0] wete_inc;   // Trailing edge one cycle later
   logic                      wele_early; // Leading edge count below 2
   logic                      full_next;

   // Write when not storing read data, direction from new or held access
   assign wr_cond = (smc_nextstate != SMC_STORE) &
                    ((n_read & valid_access) | (n_r_read & ~valid_access));
   assign wr_drive = wr_cond;

   // --------------------------------------------------
   // Byte enables and write strobe
   // --------------------------------------------------
   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
      begin
         n_r_we <= '1;
         n_r_wr <= 1'b1;
      end
      else if (wr_cond)
      begin
         n_r_we <= n_be;
         n_r_wr <= 1'b0;
      end
      else
      begin
         n_r_we <= '1;   // All lanes released
         n_r_wr <= 1'b1;
      end
   end

   // --------------------------------------------------
   // Full-cycle decision
   // --------------------------------------------------
   assign count_hi   = tim.ws_count[ws_width-1:SMC_EDGE_WIDTH];
   assign count_lo   = tim.ws_count[SMC_EDGE_WIDTH-1:0];
   assign store_hi   = tim.ws_store[ws_width-1:SMC_EDGE_WIDTH];
   assign store_lo   = tim.ws_store[SMC_EDGE_WIDTH-1:0];
   assign wete_inc   = tim.wete_store + SMC_EDGE_WIDTH'(1);
   assign wele_early = tim.wele_count < SMC_EDGE_WIDTH'(2);

   always_comb
   begin
      full_next = 1'b0;
      if (smc_nextstate == SMC_RW)
      begin
         case (r_smc_currentstate)
            SMC_LE:
               full_next = wele_early & ((count_hi != '0) | (tim.wete_store < count_lo));
            SMC_STORE:
               full_next = (tim.wele_count == '0) &
                           ((count_hi != '0) | (tim.wete_store < count_lo));
            SMC_RW, SMC_FLOAT:
            begin
               if (valid_access)
                  full_next = 1'b0;          // New access restarts timing
               else if (smc_done)
                  full_next = (tim.wele_store == '0) &
                              ((store_hi != '0) | (tim.wete_store < store_lo));
               else if (tim.wete_store == SMC_EDGE_WIDTH'(3))
                  full_next = (tim.ws_count > ws_width'(4)) & wele_early;
               else
                  full_next = wele_early & ((count_hi != '0) | (wete_inc < count_lo));
            end
            default:
               full_next = 1'b0;             // Idle
         endcase
      end
   end

   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
         r_full <= 1'b0;
      else
         r_full <= full_next;
   end

   // Released write strobe means every byte lane released too
   a_wr_idle_lanes: assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1)
      n_r_wr |-> (&n_r_we));

endmodule

// ==== design/smc_bus_ctrl.sv ====
// SMC bus control stage, registers the external output-enable and the busy flag
module smc_bus_ctrl
   import smc_pkg::*;
(
   input  logic       sys_clk1,
   input  logic       n_sys_reset1,
   input  logic       wr_drive,       // Write path wants the data bus
   input  logic       valid_access,
   input  smc_state_e smc_nextstate,
   output logic       smc_n_ext_oe,   // External bus driver enable, active low
   output logic       smc_busy        // Controller active
);

   logic oe_next;
   logic active_next;  // Controller leaving or staying out of idle

   assign active_next = (smc_nextstate != SMC_IDLE);
   assign oe_next     = wr_drive & (valid_access | active_next);

   // --------------------------------------------------
   // Registered outputs
   // --------------------------------------------------
   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
      begin
         smc_n_ext_oe <= 1'b1;
         smc_busy     <= 1'b0;
      end
      else
      begin
         smc_n_ext_oe <= ~oe_next;   // Drive pins only while writing
         smc_busy     <= active_next;
      end
   end

   // Pins never driven out of reset
   a_no_oe_in_reset: assert property (@(posedge sys_clk1)
      !n_sys_reset1 |-> smc_n_ext_oe);

endmodule

// ==== design/smc_strobe_top.sv ====
// SMC strobe generation top, plain bus ports around the capture, read, write and bus stages
module smc_strobe_top
   import smc_pkg::*;
#(
   parameter int ws_width  = SMC_WS_WIDTH,
   parameter int num_bytes = SMC_NUM_BYTES
)
(
   input  logic                      sys_clk1,
   input  logic                      n_sys_reset1,
   input  logic                      valid_access,
   input  logic                      n_read,
   input  logic                      cs,
   input  smc_state_e                r_smc_currentstate,
   input  smc_state_e                smc_nextstate,
   input  logic [num_bytes-1:0]      n_be,
   input  logic [SMC_EDGE_WIDTH-1:0] r_wele_count,
   input  logic [SMC_EDGE_WIDTH-1:0] r_wele_store,
   input  logic [SMC_EDGE_WIDTH-1:0] r_wete_store,
   input  logic [SMC_EDGE_WIDTH-1:0] r_oete_store,
   input  logic [ws_width-1:0]       r_ws_count,
   input  logic [ws_width-1:0]       r_ws_store,
   input  logic                      smc_done,
   input  logic                      mac_done,
   output logic                      smc_n_rd,
   output logic                      smc_n_ext_oe,
   output logic                      smc_busy,
   output logic                      n_r_read,
   output logic                      r_cs,
   output logic                      r_full,
   output logic [num_bytes-1:0]      n_r_we,
   output logic                      n_r_wr
);

   logic wr_drive;  // Write path to bus control

   // --------------------------------------------------
   // Timing bundle
   // --------------------------------------------------
   smc_timing_if #(.ws_width(ws_width)) timing_if_inst ();

   assign timing_if_inst.ws_count   = r_ws_count;
   assign timing_if_inst.ws_store   = r_ws_store;
   assign timing_if_inst.wele_count = r_wele_count;
   assign timing_if_inst.wele_store = r_wele_store;
   assign timing_if_inst.wete_store = r_wete_store;
   assign timing_if_inst.oete_store = r_oete_store;

   smc_access_hold smc_access_hold_inst (
      .sys_clk1, .n_sys_reset1, .valid_access, .n_read, .cs,
      .smc_done, .mac_done, .n_r_read, .r_cs
   );

   smc_rd_strobe #(.ws_width(ws_width)) smc_rd_strobe_inst (
      .sys_clk1, .n_sys_reset1, .valid_access, .n_read, .n_r_read,
      .r_smc_currentstate, .smc_nextstate,
      .tim      (timing_if_inst.rd_mp),
      .smc_n_rd
   );

   smc_wr_strobe #(.ws_width(ws_width), .num_bytes(num_bytes)) smc_wr_strobe_inst (
      .sys_clk1, .n_sys_reset1, .valid_access, .n_read, .n_r_read,
      .smc_done, .n_be, .r_smc_currentstate, .smc_nextstate,
      .tim      (timing_if_inst.wr_mp),
      .wr_drive, .n_r_we, .n_r_wr, .r_full
   );

   smc_bus_ctrl smc_bus_ctrl_inst (
      .sys_clk1, .n_sys_reset1, .wr_drive, .valid_access,
      .smc_nextstate, .smc_n_ext_oe, .smc_busy
   );

endmodule

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and reset source, 10 ns clock and a 3-cycle active-low reset
module tb_clk_gen
(
   output logic sys_clk1,
   output logic n_sys_reset1
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_HALF   = 5;  // Half of the 10 ns period
   localparam int RST_CYCLES = 3;

   initial
   begin
      sys_clk1 = 1'b0;
      forever #CLK_HALF sys_clk1 = ~sys_clk1;
   end

   initial
   begin
      n_sys_reset1 = 1'b1;
      #1 n_sys_reset1 = 1'b0;  // Falling edge at 1 ns fires the asynchronous reset
      repeat (RST_CYCLES) @(posedge sys_clk1);
      @(negedge sys_clk1);
      n_sys_reset1 = 1'b1;     // Released away from the rising edge
   end

endmodule

// ==== verif/smc_strobe_tb.sv ====
// SMC strobe testbench with random and directed stimulus checked by reference-model assertions
module smc_strobe_tb
   import smc_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WS_WIDTH    = 8;
   localparam int NUM_BYTES   = 4;
   localparam int RST_CYCLES  = 3;
   localparam int RAND_CYCLES = 2000;
   localparam int DIR_CYCLES  = 200;   // Zero wait values reach the read strobe branches
   localparam int CLK_PERIOD  = 10;
   localparam int TIMEOUT_NS  = 2 * (RST_CYCLES + RAND_CYCLES + DIR_CYCLES + 3) * CLK_PERIOD;
   localparam logic [NUM_BYTES+6:0] RESET_VEC = {6'b110000, {NUM_BYTES{1'b1}}, 1'b1};

   logic                 sys_clk1, n_sys_reset1;
   logic                 valid_access, n_read, cs, smc_done, mac_done;
   smc_state_e           r_smc_currentstate, smc_nextstate;
   logic [NUM_BYTES-1:0] n_be;
   logic [1:0]           r_wele_count, r_wele_store, r_wete_store, r_oete_store;
   logic [WS_WIDTH-1:0]  r_ws_count, r_ws_store;
   logic                 smc_n_rd, smc_n_ext_oe, smc_busy, n_r_read, r_cs, r_full, n_r_wr;
   logic [NUM_BYTES-1:0] n_r_we;
   logic [NUM_BYTES+6:0] out_vec;   // All outputs for the reset check
   int                   seed;
   int                   error_count = 0;
   int                   cycle_cnt = 0;

   // Reference model state one cycle behind the inputs
   logic                 exp_n_rd, exp_n_ext_oe, exp_busy, exp_n_r_read, exp_r_cs;
   logic                 exp_full, exp_n_r_wr;
   logic [NUM_BYTES-1:0] exp_n_r_we;
   logic                 wr_now;    // Write condition this cycle

   tb_clk_gen clk_gen_inst (.sys_clk1, .n_sys_reset1);

   smc_strobe_top #(.ws_width(WS_WIDTH), .num_bytes(NUM_BYTES)) smc_strobe_top_inst (.*);

   assign out_vec = {smc_n_rd, smc_n_ext_oe, smc_busy, n_r_read, r_cs, r_full, n_r_we, n_r_wr};

   task automatic flag_mismatch(input string name, input logic [15:0] exp_val,
                                input logic [15:0] act_val);
      error_count++;
      $display("Error: %s expected 0x%h got 0x%h at %0t", name, exp_val, act_val, $time);
   endtask

   function automatic smc_state_e pick_state(input int unsigned idx);
      smc_state_e st;
      case (idx % 5)
         0:       st = SMC_IDLE;
         1:       st = SMC_LE;
         2:       st = SMC_RW;
         3:       st = SMC_STORE;
         default: st = SMC_FLOAT;
      endcase
      return st;
   endfunction

   // --------------------------------------------------
   // Expected values from the block rules
   // --------------------------------------------------
   function automatic logic read_gate(input logic [WS_WIDTH-1:0] ws, input logic [1:0] oete,
                                      input logic incl);
      logic in_window;
      in_window = incl ? (oete <= ws[1:0]) : (oete < ws[1:0]);  // Store form is inclusive
      return (~|ws) || (|ws[WS_WIDTH-1:2]) || in_window;
   endfunction

   function automatic logic full_rule(input logic wele_ok, input logic [WS_WIDTH-1:0] ws,
                                      input logic [2:0] wete);
      return wele_ok && ((|ws[WS_WIDTH-1:2]) || (wete < {1'b0, ws[1:0]}));
   endfunction

   function automatic logic next_rd();
      logic rd;
      if (smc_nextstate != SMC_RW)
         rd = 1'b1;
      else if (valid_access)
         rd = n_read;
      else if (r_smc_currentstate == SMC_LE || r_smc_currentstate == SMC_STORE)
         rd = read_gate(r_ws_store, r_oete_store, 1'b1) ? exp_n_r_read : 1'b1;
      else
         rd = read_gate(r_ws_count, r_oete_store, 1'b0) ? exp_n_r_read : 1'b1;
      return rd;
   endfunction

   function automatic logic next_full();
      logic full;
      full = 1'b0;
      if (smc_nextstate == SMC_RW)
      begin
         case (r_smc_currentstate)
            SMC_LE:    full = full_rule(r_wele_count < 2'd2, r_ws_count, {1'b0, r_wete_store});
            SMC_STORE: full = full_rule(r_wele_count == 2'd0, r_ws_count, {1'b0, r_wete_store});
            SMC_RW, SMC_FLOAT:
            begin
               if (valid_access)
                  full = 1'b0;
               else if (smc_done)
                  full = full_rule(r_wele_store == 2'd0, r_ws_store, {1'b0, r_wete_store});
               else if (r_wete_store == 2'd3)
                  full = (r_ws_count > 8'd4) && (r_wele_count < 2'd2);
               else
                  full = full_rule(r_wele_count < 2'd2, r_ws_count, {1'b0, r_wete_store} + 3'd1);
            end
            default:   full = 1'b0;
         endcase
      end
      return full;
   endfunction

   assign wr_now = (smc_nextstate != SMC_STORE) &&
                   ((n_read && valid_access) || (exp_n_r_read && !valid_access));

   always_ff @(posedge sys_clk1 or negedge n_sys_reset1)
   begin
      if (!n_sys_reset1)
      begin
         {exp_n_rd, exp_n_ext_oe, exp_n_r_wr, exp_n_r_we} <= '1;
         {exp_busy, exp_n_r_read, exp_r_cs, exp_full}     <= '0;
      end
      else
      begin
         if (valid_access)
         begin
            exp_n_r_read <= n_read;   // Load wins over done
            exp_r_cs     <= cs;
         end
         else if (smc_done && mac_done)
         begin
            exp_n_r_read <= 1'b0;
            exp_r_cs     <= 1'b0;
         end
         exp_n_r_we   <= wr_now ? n_be : '1;
         exp_n_r_wr   <= !wr_now;
         exp_n_ext_oe <= !(wr_now && (valid_access || smc_nextstate != SMC_IDLE));
         exp_busy     <= (smc_nextstate != SMC_IDLE);
         exp_n_rd     <= next_rd();
         exp_full     <= next_full();
      end
   end

   always_ff @(posedge sys_clk1)
      cycle_cnt <= cycle_cnt + 1;

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   a_reset: assert property (@(posedge sys_clk1)
      (cycle_cnt != 0 && !$past(n_sys_reset1)) |-> out_vec == RESET_VEC)
      else flag_mismatch("out_vec", 16'(RESET_VEC), 16'($sampled(out_vec)));
   a_busy: assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1) smc_busy == exp_busy)
      else flag_mismatch("smc_busy", 16'($sampled(exp_busy)), 16'($sampled(smc_busy)));
   a_read: assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1)
      n_r_read == exp_n_r_read)
      else flag_mismatch("n_r_read", 16'($sampled(exp_n_r_read)), 16'($sampled(n_r_read)));
   a_cs: assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1) r_cs == exp_r_cs)
      else flag_mismatch("r_cs", 16'($sampled(exp_r_cs)), 16'($sampled(r_cs)));
   a_we: assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1) n_r_we == exp_n_r_we)
      else flag_mismatch("n_r_we", 16'($sampled(exp_n_r_we)), 16'($sampled(n_r_we)));
   a_wr: assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1) n_r_wr == exp_n_r_wr)
      else flag_mismatch("n_r_wr", 16'($sampled(exp_n_r_wr)), 16'($sampled(n_r_wr)));
   a_oe: assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1)
      smc_n_ext_oe == exp_n_ext_oe)
      else flag_mismatch("smc_n_ext_oe", 16'($sampled(exp_n_ext_oe)),
                         16'($sampled(smc_n_ext_oe)));
   a_rd: assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1) smc_n_rd == exp_n_rd)
      else flag_mismatch("smc_n_rd", 16'($sampled(exp_n_rd)), 16'($sampled(smc_n_rd)));
   a_full: assert property (@(posedge sys_clk1) disable iff (!n_sys_reset1) r_full == exp_full)
      else flag_mismatch("r_full", 16'($sampled(exp_full)), 16'($sampled(r_full)));

   // --------------------------------------------------
   // Stimulus on the falling edge
   // --------------------------------------------------
   task automatic drive_random();
      logic small_wait;
      small_wait         = 1'($random(seed));
      valid_access       = ($unsigned($random(seed)) % 4) == 0;  // About one in four
      n_read             = 1'($random(seed));
      cs                 = 1'($random(seed));
      smc_done           = 1'($random(seed));
      mac_done           = 1'($random(seed));
      r_smc_currentstate = pick_state($unsigned($random(seed)));
      smc_nextstate      = pick_state($unsigned($random(seed)));
      n_be               = NUM_BYTES'($random(seed));
      r_wele_count       = 2'($random(seed));
      r_wele_store       = 2'($random(seed));
      r_wete_store       = 2'($random(seed));
      r_oete_store       = 2'($random(seed));
      r_ws_count         = small_wait ? WS_WIDTH'($random(seed) & 7) : WS_WIDTH'($random(seed));
      r_ws_store         = small_wait ? WS_WIDTH'($random(seed) & 7) : WS_WIDTH'($random(seed));
   endtask

   task automatic drive_directed();
      drive_random();
      r_ws_store   = '0;
      r_ws_count   = '0;
      r_oete_store = '0;
      if (($unsigned($random(seed)) % 8) != 0)
         smc_nextstate = SMC_RW;  // Mostly inside the strobe window
   endtask

   initial
   begin
      seed               = 75282;
      {valid_access, n_read, cs, smc_done, mac_done} = '0;
      r_smc_currentstate = SMC_IDLE;
      smc_nextstate      = SMC_IDLE;
      n_be               = '1;
      {r_wele_count, r_wele_store, r_wete_store, r_oete_store} = '0;
      r_ws_count         = '0;
      r_ws_store         = '0;
      @(posedge n_sys_reset1);
      repeat (RAND_CYCLES)
      begin
         @(negedge sys_clk1);
         drive_random();
      end
      repeat (DIR_CYCLES)
      begin
         @(negedge sys_clk1);
         drive_directed();
      end
      repeat (2) @(negedge sys_clk1);  // Last inputs reach the checks
      $display("Summary: %0d errors over %0d cycles", error_count, cycle_cnt);
      if (error_count == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // Watchdog
   initial
   begin
      #TIMEOUT_NS;
      $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("Errors found");
      $finish;
   end

endmodule

// ==== compile.f ====
design/smc_pkg.sv
design/smc_timing_if.sv
design/smc_access_hold.sv
design/smc_rd_strobe.sv
design/smc_wr_strobe.sv
design/smc_bus_ctrl.sv
design/smc_strobe_top.sv
verif/tb_clk_gen.sv
verif/smc_strobe_tb.sv

// ==== Makefile ====
# Verilator flow for the SMC strobe block
TOP       ?= smc_strobe_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
TSCALE    ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TSCALE)
FAIL_MSG  ?= Errors found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TSCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
